// ==== ctrl_top.f ====
+incdir+source
+incdir+tests
source/ctrl_pkg.sv
source/ctrl_if.sv
source/exc_detect.sv
source/irq_arbiter.sv
source/ctrl_fsm.sv
source/ctrl_top.sv
tests/ctrl_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ctrl_tb
FILELIST  = ctrl_top.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/ctrl_tb_cases.svh ====
/*
 * stimulus and expected results, applied in order
 * the last interrupt row is an NMI and leaves NMI mode set
 */
`ifndef CTRL_TB_CASES_SVH
`define CTRL_TB_CASES_SVH

// where the trap value comes from in FLUSH
typedef enum logic [2:0] {TVAL_ZERO, TVAL_PC, TVAL_INSN, TVAL_CINSN, TVAL_LSU} tval_src_e;

// decoder and lsu flags, then expected cause and trap value source
typedef struct packed {
  logic             fetch_err;
  logic             illegal;
  logic             ecall;
  logic             ebrk;
  logic             store_err;
  logic             load_err;
  logic             compressed;
  ctrl_pkg::cause_t cause;
  tval_src_e        tval;
} exc_case_t;

// pending interrupt inputs, then expected cause
typedef struct packed {
  logic                nm;
  ctrl_pkg::fast_irq_t fast;
  logic                ext;
  logic                sw;
  logic                tmr;
  ctrl_pkg::cause_t    cause;
} irq_case_t;

localparam int NUM_EXC_CASES = 10;
localparam int NUM_IRQ_CASES = 6;

exc_case_t exc_cases [NUM_EXC_CASES];
irq_case_t irq_cases [NUM_IRQ_CASES];

task automatic load_case_tables();
  // fetch, illegal, ecall, ebrk, store, load, compressed
  exc_cases[0] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, `CTRL_EXC_FETCH_FAULT, TVAL_PC};
  exc_cases[1] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, `CTRL_EXC_FETCH_FAULT, TVAL_PC};
  exc_cases[2] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, `CTRL_EXC_ILLEGAL, TVAL_CINSN};
  exc_cases[3] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, `CTRL_EXC_ILLEGAL, TVAL_INSN};
  exc_cases[4] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, `CTRL_EXC_ILLEGAL, TVAL_INSN};
  exc_cases[5] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, `CTRL_EXC_ECALL_M, TVAL_ZERO};
  exc_cases[6] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, `CTRL_EXC_BREAKPOINT, TVAL_ZERO};
  exc_cases[7] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, `CTRL_EXC_STORE_FAULT, TVAL_LSU};
  exc_cases[8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, `CTRL_EXC_LOAD_FAULT, TVAL_LSU};
  exc_cases[9] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, `CTRL_EXC_BREAKPOINT, TVAL_ZERO};
  // nmi, fast lines, external, software, timer
  irq_cases[0] = '{1'b0, 15'h4010, 1'b1, 1'b1, 1'b1, `CTRL_IRQ_FAST_BASE + 6'd14};
  irq_cases[1] = '{1'b0, 15'h0001, 1'b1, 1'b0, 1'b0, `CTRL_IRQ_FAST_BASE};
  irq_cases[2] = '{1'b0, 15'h0000, 1'b1, 1'b1, 1'b1, `CTRL_IRQ_EXT};
  irq_cases[3] = '{1'b0, 15'h0000, 1'b0, 1'b1, 1'b1, `CTRL_IRQ_SW};
  irq_cases[4] = '{1'b0, 15'h0000, 1'b0, 1'b0, 1'b1, `CTRL_IRQ_TIMER};
  irq_cases[5] = '{1'b1, 15'h0004, 1'b1, 1'b0, 1'b0, `CTRL_IRQ_NM};
endtask

`endif

// ==== tests/ctrl_tb.sv ====
/*
 * drives ctrl_top through boot, traps, MRET, sleep and stall sequences
 * inputs change on the falling edge, outputs are checked there as well
 * decoder flags are held until the FSM is back in DECODE
 */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module ctrl_tb;

  localparam int CLK_HALF = 50;
  // output selectors for the wait loop
  localparam int OUT_PC_SET      = 0;
  localparam int OUT_FIRST_FETCH = 1;
  localparam int OUT_BUSY        = 2;

  logic clk_i;
  logic rst_ni;
  logic fetch_enable_i;
  logic instr_valid_i, illegal_insn_i, ecall_insn_i, mret_insn_i, wfi_insn_i, ebrk_insn_i;
  logic instr_fetch_err_i, instr_is_compressed_i, load_err_i, store_err_i;
  logic branch_set_i, jump_set_i;
  logic csr_mstatus_mie_i, irq_pending_i, irq_nm_i, csr_msip_i, csr_meip_i, csr_mtip_i;
  logic stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i;
  ctrl_pkg::word_t       instr_i, pc_id_i, lsu_addr_last_i, csr_mtval_o;
  ctrl_pkg::cinsn_t      instr_compressed_i;
  ctrl_pkg::fast_irq_t   csr_mfip_i;
  logic ctrl_busy_o, first_fetch_o, instr_valid_clear_o, id_in_ready_o, instr_req_o;
  logic pc_set_o, csr_save_if_o, csr_save_id_o, csr_restore_mret_id_o, csr_save_cause_o;
  ctrl_pkg::pc_sel_e     pc_mux_o;
  ctrl_pkg::exc_pc_sel_e exc_pc_mux_o;
  ctrl_pkg::cause_t      exc_cause_o;
  integer                seed;

  `include "ctrl_tb_cases.svh"

  ctrl_top u_dut (.*);

  always #CLK_HALF clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_cause(input string name, input ctrl_pkg::cause_t got,
                             input ctrl_pkg::cause_t exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_word(input string name, input ctrl_pkg::word_t got,
                            input ctrl_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_pc_sel(input string name, input ctrl_pkg::pc_sel_e got,
                              input ctrl_pkg::pc_sel_e exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_exc_pc(input string name, input ctrl_pkg::exc_pc_sel_e got,
                              input ctrl_pkg::exc_pc_sel_e exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // step falling edges until the selected output has the value
  task automatic wait_for_output(input int sel, input logic value, input int limit,
                                 input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk_i);
      cycles++;
      case (sel)
        OUT_PC_SET:      seen = (pc_set_o === value);
        OUT_FIRST_FETCH: seen = (first_fetch_o === value);
        default:         seen = (ctrl_busy_o === value);
      endcase
      if (!seen && cycles >= limit) begin
        $display("timeout after %0d cycles waiting for %s", cycles, what);
        stop_on_failure();
      end
    end
  endtask

  // no redirect at all for a number of cycles
  task automatic expect_no_trap(input int cycles, input string why);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
      if (pc_set_o) begin
        $display("unexpected fetch redirect while %s", why);
        stop_on_failure();
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic clear_decode();
    instr_valid_i         = 1'b0;
    illegal_insn_i        = 1'b0;
    ecall_insn_i          = 1'b0;
    mret_insn_i           = 1'b0;
    wfi_insn_i            = 1'b0;
    ebrk_insn_i           = 1'b0;
    instr_fetch_err_i     = 1'b0;
    instr_is_compressed_i = 1'b0;
    load_err_i            = 1'b0;
    store_err_i           = 1'b0;
    branch_set_i          = 1'b0;
    jump_set_i            = 1'b0;
  endtask

  task automatic clear_irq();
    csr_mstatus_mie_i = 1'b0;
    irq_pending_i     = 1'b0;
    irq_nm_i          = 1'b0;
    csr_msip_i        = 1'b0;
    csr_meip_i        = 1'b0;
    csr_mtip_i        = 1'b0;
    csr_mfip_i        = '0;
  endtask

  task automatic randomize_operands();
    ctrl_pkg::word_t rnd;
    instr_i            = $random(seed);
    pc_id_i            = $random(seed);
    lsu_addr_last_i    = $random(seed);
    rnd                = $random(seed);
    instr_compressed_i = rnd[15:0];
  endtask

  // trap value from the driven operands
  function automatic ctrl_pkg::word_t expected_tval(input tval_src_e src);
    case (src)
      TVAL_PC:    return pc_id_i;
      TVAL_INSN:  return instr_i;
      TVAL_CINSN: return {16'h0000, instr_compressed_i};
      TVAL_LSU:   return lsu_addr_last_i;
      default:    return '0;
    endcase
  endfunction

  task automatic run_exc_case(input exc_case_t c);
    @(negedge clk_i);
    randomize_operands();
    instr_valid_i         = 1'b1;
    instr_fetch_err_i     = c.fetch_err;
    illegal_insn_i        = c.illegal;
    ecall_insn_i          = c.ecall;
    ebrk_insn_i           = c.ebrk;
    store_err_i           = c.store_err;
    load_err_i            = c.load_err;
    instr_is_compressed_i = c.compressed;
    // one cycle of latency into FLUSH
    wait_for_output(OUT_PC_SET, 1'b1, 1, "exception entry");
    check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_EXC);
    check_exc_pc("exc_pc_mux_o", exc_pc_mux_o, ctrl_pkg::EXC_PC_EXC);
    check_bit("csr_save_id_o", csr_save_id_o, 1'b1);
    check_bit("csr_save_cause_o", csr_save_cause_o, 1'b1);
    check_cause("exc_cause_o", exc_cause_o, c.cause);
    check_word("csr_mtval_o", csr_mtval_o, expected_tval(c.tval));
    @(negedge clk_i);
    clear_decode();
  endtask

  task automatic check_irq_entry(input ctrl_pkg::cause_t cause);
    check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_EXC);
    check_exc_pc("exc_pc_mux_o", exc_pc_mux_o, ctrl_pkg::EXC_PC_IRQ);
    check_bit("csr_save_if_o", csr_save_if_o, 1'b1);
    check_bit("csr_save_cause_o", csr_save_cause_o, 1'b1);
    check_cause("exc_cause_o", exc_cause_o, cause);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 43;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    stall_lsu_i     = 1'b0;
    stall_multdiv_i = 1'b0;
    stall_jump_i    = 1'b0;
    stall_branch_i  = 1'b0;
    instr_i            = '0;
    pc_id_i            = '0;
    lsu_addr_last_i    = '0;
    instr_compressed_i = '0;
    clear_decode();
    clear_irq();
    load_case_tables();

    // boot
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_BOOT);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    check_bit("csr_save_if_o", csr_save_if_o, 1'b0);
    check_bit("csr_save_id_o", csr_save_id_o, 1'b0);
    check_bit("csr_save_cause_o", csr_save_cause_o, 1'b0);
    check_bit("csr_restore_mret_id_o", csr_restore_mret_id_o, 1'b0);
    fetch_enable_i = 1'b1;
    // one cycle in BOOT_SET before the first fetch
    @(negedge clk_i);
    check_bit("first_fetch_o", first_fetch_o, 1'b0);
    wait_for_output(OUT_FIRST_FETCH, 1'b1, 1, "first fetch after boot");

    for (int i = 0; i < NUM_EXC_CASES; i++) begin
      run_exc_case(exc_cases[i]);
    end

    // taken branch redirects in the decode cycle itself
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    branch_set_i  = 1'b1;
    #(CLK_HALF / 2);
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_JUMP);
    @(negedge clk_i);
    clear_decode();

    // interrupt waits for a multicycle instruction to finish
    stall_multdiv_i   = 1'b1;
    csr_mstatus_mie_i = 1'b1;
    irq_pending_i     = 1'b1;
    csr_mtip_i        = 1'b1;
    expect_no_trap(4, "a stall input is high");
    check_bit("id_in_ready_o", id_in_ready_o, 1'b0);
    check_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b0);
    stall_multdiv_i = 1'b0;
    wait_for_output(OUT_PC_SET, 1'b1, 2, "interrupt entry after the stall");
    check_irq_entry(`CTRL_IRQ_TIMER);
    @(negedge clk_i);
    clear_irq();

    for (int i = 0; i < NUM_IRQ_CASES; i++) begin
      @(negedge clk_i);
      csr_mstatus_mie_i = 1'b1;
      irq_nm_i          = irq_cases[i].nm;
      csr_mfip_i        = irq_cases[i].fast;
      csr_meip_i        = irq_cases[i].ext;
      csr_msip_i        = irq_cases[i].sw;
      csr_mtip_i        = irq_cases[i].tmr;
      irq_pending_i     = (|irq_cases[i].fast) | irq_cases[i].ext |
                          irq_cases[i].sw | irq_cases[i].tmr;
      wait_for_output(OUT_PC_SET, 1'b1, 1, "interrupt entry");
      check_irq_entry(irq_cases[i].cause);
      @(negedge clk_i);
      clear_irq();
    end

    // NMI handler still running, a second NMI must wait
    irq_nm_i = 1'b1;
    expect_no_trap(6, "an NMI handler is running");
    instr_valid_i = 1'b1;
    mret_insn_i   = 1'b1;
    wait_for_output(OUT_PC_SET, 1'b1, 1, "MRET redirect");
    check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_ERET);
    check_bit("csr_restore_mret_id_o", csr_restore_mret_id_o, 1'b1);
    check_bit("csr_save_cause_o", csr_save_cause_o, 1'b0);
    @(negedge clk_i);
    clear_decode();
    // NMI mode is clear now, the held NMI goes in
    wait_for_output(OUT_PC_SET, 1'b1, 2, "NMI entry after MRET");
    check_irq_entry(`CTRL_IRQ_NM);
    @(negedge clk_i);
    clear_irq();

    // WFI, sleep, wake on a pending interrupt
    instr_valid_i = 1'b1;
    wfi_insn_i    = 1'b1;
    wait_for_output(OUT_BUSY, 1'b0, 4, "sleep entry");
    clear_decode();
    expect_no_trap(3, "the core sleeps");
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    irq_pending_i = 1'b1;
    wait_for_output(OUT_FIRST_FETCH, 1'b1, 3, "wake-up from sleep");
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    @(negedge clk_i);
    clear_irq();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== source/ctrl_top.sv ====
/*
 * controller top level, plain ports toward the core
 * irq_pending_i is expected to be the OR of all maskable sources
 */
`timescale 1ns/1ps

module ctrl_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  // decoder and IF-ID register
  input  logic                  instr_valid_i,
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  wfi_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  instr_fetch_err_i,
  input  logic                  instr_is_compressed_i,
  input  ctrl_pkg::word_t       instr_i,
  input  ctrl_pkg::cinsn_t      instr_compressed_i,
  input  ctrl_pkg::word_t       pc_id_i,
  // lsu
  input  logic                  load_err_i,
  input  logic                  store_err_i,
  input  ctrl_pkg::word_t       lsu_addr_last_i,
  // branch and jump
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  // interrupts
  input  logic                  csr_mstatus_mie_i,
  input  logic                  irq_pending_i,
  input  logic                  irq_nm_i,
  input  logic                  csr_msip_i,
  input  logic                  csr_meip_i,
  input  logic                  csr_mtip_i,
  input  ctrl_pkg::fast_irq_t   csr_mfip_i,
  // stalls
  input  logic                  stall_lsu_i,
  input  logic                  stall_multdiv_i,
  input  logic                  stall_jump_i,
  input  logic                  stall_branch_i,
  // pipeline and fetch control
  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  instr_valid_clear_o,
  output logic                  id_in_ready_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_sel_e     pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,
  // csr save and restore
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  csr_save_cause_o,
  output ctrl_pkg::cause_t      exc_cause_o,
  output ctrl_pkg::word_t       csr_mtval_o
);

  exc_req_if exc_req ();
  irq_req_if irq_req ();

  // remaining ports match top-level names one to one
  exc_detect u_exc_detect (
    .exc_o (exc_req),
    .*
  );

  irq_arbiter u_irq_arbiter (
    .irq_o (irq_req),
    .*
  );

  ctrl_fsm u_ctrl_fsm (
    .exc_i (exc_req),
    .irq_i (irq_req),
    .*
  );

endmodule

// ==== source/ctrl_fsm.sv ====
/*
 * machine-mode only controller, no debug and no user mode
 * decoder flags must stay stable in ID while the FSM is in FLUSH
 */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module ctrl_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic                  branch_set_i,
  input  logic                  jump_set_i,
  input  logic                  instr_valid_i,
  input  logic                  instr_is_compressed_i,
  input  logic                  irq_nm_i,
  input  logic                  irq_pending_i,
  input  logic                  stall_lsu_i,
  input  logic                  stall_multdiv_i,
  input  logic                  stall_jump_i,
  input  logic                  stall_branch_i,
  input  ctrl_pkg::word_t       instr_i,
  input  ctrl_pkg::word_t       pc_id_i,
  input  ctrl_pkg::word_t       lsu_addr_last_i,
  input  ctrl_pkg::cinsn_t      instr_compressed_i,
  exc_req_if.consumer           exc_i,
  irq_req_if.consumer           irq_i,
  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  instr_valid_clear_o,
  output logic                  id_in_ready_o,
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_restore_mret_id_o,
  output logic                  csr_save_cause_o,
  output ctrl_pkg::pc_sel_e     pc_mux_o,
  output ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,
  output ctrl_pkg::cause_t      exc_cause_o,
  output ctrl_pkg::word_t       csr_mtval_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  logic                  nmi_mode_q;
  logic                  nmi_mode_d;
  logic                  stall;
  logic                  halt_if;
  logic                  flush_id;
  logic                  exc_any;

  assign exc_i.in_flush = (state_q == ctrl_pkg::FLUSH);
  assign irq_i.nmi_mode = nmi_mode_q;

  // lsu faults sit in their own flops
  assign exc_any = exc_i.exc_pending | exc_i.load_err_pending | exc_i.store_err_pending;

  ////////////////////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d               = state_q;
    nmi_mode_d            = nmi_mode_q;
    instr_req_o           = 1'b1;
    ctrl_busy_o           = 1'b1;
    first_fetch_o         = 1'b0;
    halt_if               = 1'b0;
    flush_id              = 1'b0;
    pc_set_o              = 1'b0;
    pc_mux_o              = ctrl_pkg::PC_BOOT;
    exc_pc_mux_o          = ctrl_pkg::EXC_PC_IRQ;
    exc_cause_o           = '0;
    csr_mtval_o           = '0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    csr_save_cause_o      = 1'b0;

    unique case (state_q)
      ctrl_pkg::RESET: begin
        // hold the boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = ctrl_pkg::BOOT_SET;
        end
      end
      ctrl_pkg::BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end
      ctrl_pkg::WAIT_SLEEP, ctrl_pkg::SLEEP: begin
        // core idle, IF halted and ID emptied
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        if (state_q == ctrl_pkg::WAIT_SLEEP) begin
          state_d = ctrl_pkg::SLEEP;
        end else if (irq_nm_i || irq_pending_i) begin
          state_d = ctrl_pkg::FIRST_FETCH;
        end
      end
      ctrl_pkg::FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        if (!stall) begin
          state_d = ctrl_pkg::DECODE;
        end
        // pipeline is empty here, interrupt goes straight in
        if (irq_i.take_irq) begin
          state_d  = ctrl_pkg::IRQ_TAKEN;
          halt_if  = 1'b1;
          flush_id = 1'b1;
        end
      end
      ctrl_pkg::DECODE: begin
        if (instr_valid_i) begin
          if (exc_i.special_req) begin
            // keep the instruction in ID for FLUSH to inspect
            state_d = ctrl_pkg::FLUSH;
            halt_if = 1'b1;
          end else if (branch_set_i || jump_set_i) begin
            pc_set_o = 1'b1;
            pc_mux_o = ctrl_pkg::PC_JUMP;
          end
          // multicycle instr still running, hold IF until it retires
          if (irq_i.take_irq && stall) begin
            halt_if = 1'b1;
          end
        end
        if (!stall && !exc_i.special_req && irq_i.take_irq) begin
          state_d  = ctrl_pkg::IRQ_TAKEN;
          halt_if  = 1'b1;
          flush_id = 1'b1;
        end
      end
      ctrl_pkg::IRQ_TAKEN: begin
        // pending state may have dropped meanwhile, then just resume
        if (irq_i.take_irq) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_EXC;
          exc_pc_mux_o     = ctrl_pkg::EXC_PC_IRQ;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq_i.irq_cause;
          if (irq_i.irq_is_nmi) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = ctrl_pkg::DECODE;
      end
      ctrl_pkg::FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = ctrl_pkg::DECODE;
        if (exc_any) begin
          pc_set_o         = 1'b1;
          pc_mux_o         = ctrl_pkg::PC_EXC;
          exc_pc_mux_o     = ctrl_pkg::EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          // synchronous exception priority, highest first
          if (exc_i.fetch_err) begin
            exc_cause_o = `CTRL_EXC_FETCH_FAULT;
            csr_mtval_o = pc_id_i;
          end else if (exc_i.illegal_pending) begin
            exc_cause_o = `CTRL_EXC_ILLEGAL;
            csr_mtval_o = instr_is_compressed_i ? {16'b0, instr_compressed_i} : instr_i;
          end else if (exc_i.ecall) begin
            exc_cause_o = `CTRL_EXC_ECALL_M;
          end else if (exc_i.ebrk) begin
            exc_cause_o = `CTRL_EXC_BREAKPOINT;
          end else if (exc_i.store_err_pending) begin
            exc_cause_o = `CTRL_EXC_STORE_FAULT;
            csr_mtval_o = lsu_addr_last_i;
          end else begin
            exc_cause_o = `CTRL_EXC_LOAD_FAULT;
            csr_mtval_o = lsu_addr_last_i;
          end
        end else if (exc_i.mret) begin
          // return from trap, also leaves an NMI handler
          pc_set_o              = 1'b1;
          pc_mux_o              = ctrl_pkg::PC_ERET;
          csr_restore_mret_id_o = 1'b1;
          nmi_mode_d            = 1'b0;
        end else if (exc_i.wfi) begin
          state_d = ctrl_pkg::WAIT_SLEEP;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // stall control
  ////////////////////////////////////////////////////////////////////////////

  // current instr needs at least one more cycle
  assign stall = stall_lsu_i | stall_multdiv_i | stall_jump_i | stall_branch_i;

  assign id_in_ready_o = ~stall & ~halt_if;

  // halt keeps the ID instr valid unless it is flushed as well
  assign instr_valid_clear_o = ~(stall | halt_if) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ctrl_pkg::RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

  // state register never picks up an undefined encoding
  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(state_q)
  );

  // ID holds the decoder flags while FLUSH picks the cause from them
  a_flush_flags_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == ctrl_pkg::FLUSH) |-> $stable({exc_i.fetch_err, exc_i.ecall, exc_i.ebrk,
                                              exc_i.mret, exc_i.wfi})
  );

endmodule

// ==== source/irq_arbiter.sv ====
/*
 * combinational interrupt decision, no state held here
 * NMI is blocked while the FSM reports NMI mode
 */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module irq_arbiter (
  input  logic                csr_mstatus_mie_i,
  input  logic                irq_pending_i,
  input  logic                irq_nm_i,
  input  logic                csr_msip_i,
  input  logic                csr_meip_i,
  input  logic                csr_mtip_i,
  input  ctrl_pkg::fast_irq_t csr_mfip_i,
  irq_req_if.producer         irq_o
);

  logic [3:0] fast_idx;

  // NMI only counts outside an NMI handler
  assign irq_o.irq_is_nmi = irq_nm_i & ~irq_o.nmi_mode;

  // maskable ones need the global enable
  assign irq_o.take_irq = irq_o.irq_is_nmi | (irq_pending_i & csr_mstatus_mie_i);

  // highest pending fast line wins, later iterations override
  always_comb begin
    fast_idx = 4'd0;
    for (int i = 0; i < `CTRL_NFAST; i++) begin
      if (csr_mfip_i[i]) begin
        fast_idx = 4'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // cause encoding
  //////////////////////////////////////////////////////////////////////////

  // NMI, fast, external, software, timer
  always_comb begin
    irq_o.irq_cause = '0;
    if (irq_o.irq_is_nmi) begin
      irq_o.irq_cause = `CTRL_IRQ_NM;
    end else if (|csr_mfip_i) begin
      irq_o.irq_cause = `CTRL_IRQ_FAST_BASE + {2'b00, fast_idx};
    end else if (csr_meip_i) begin
      irq_o.irq_cause = `CTRL_IRQ_EXT;
    end else if (csr_msip_i) begin
      irq_o.irq_cause = `CTRL_IRQ_SW;
    end else if (csr_mtip_i) begin
      irq_o.irq_cause = `CTRL_IRQ_TIMER;
    end
  end

  // the cause handed to the CSRs must be defined whenever the FSM may use it
  a_cause_known: assert final (!(irq_o.take_irq && $isunknown(irq_o.irq_cause)));

endmodule

// ==== source/exc_detect.sv ====
/*
 * decoder flags are only meaningful with instr_valid_i, masked here
 * exception requests take one register stage, seen by the FSM in FLUSH
 */
`timescale 1ns/1ps

module exc_detect (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic illegal_insn_i,
  input  logic ecall_insn_i,
  input  logic mret_insn_i,
  input  logic wfi_insn_i,
  input  logic ebrk_insn_i,
  input  logic instr_fetch_err_i,
  input  logic load_err_i,
  input  logic store_err_i,
  exc_req_if.producer exc_o
);

  logic illegal_d;
  logic illegal_q;
  logic exc_req_d;
  logic exc_req_q;
  logic load_err_d;
  logic load_err_q;
  logic store_err_d;
  logic store_err_q;

  // decoder flags qualified with a valid instruction in ID
  assign exc_o.fetch_err = instr_fetch_err_i & instr_valid_i;
  assign exc_o.ecall     = ecall_insn_i & instr_valid_i;
  assign exc_o.ebrk      = ebrk_insn_i & instr_valid_i;
  assign exc_o.mret      = mret_insn_i & instr_valid_i;
  assign exc_o.wfi       = wfi_insn_i & instr_valid_i;

  // clear in FLUSH so a handled request does not fire twice
  assign illegal_d   = illegal_insn_i & instr_valid_i & ~exc_o.in_flush;
  assign exc_req_d   = (exc_o.ecall | exc_o.ebrk | exc_o.fetch_err | illegal_d) &
                       ~exc_o.in_flush;
  assign load_err_d  = load_err_i & ~exc_o.in_flush;
  assign store_err_d = store_err_i & ~exc_o.in_flush;

  // anything that must leave DECODE through FLUSH
  // lsu faults arrive for one cycle only, so use them unregistered here
  assign exc_o.special_req = exc_o.mret | exc_o.wfi | exc_req_d | load_err_i | store_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  assign exc_o.exc_pending       = exc_req_q;
  assign exc_o.illegal_pending   = illegal_q;
  assign exc_o.load_err_pending  = load_err_q;
  assign exc_o.store_err_pending = store_err_q;

  // lsu reports at most one fault per access
  a_lsu_fault_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(load_err_i && store_err_i)
  );

endmodule

// ==== source/ctrl_if.sv ====
/*
 * request bundles from the exception and interrupt blocks to the FSM
 * pending flags are one cycle behind decode and drop while in_flush is high
 */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

// exception and special instruction requests
interface exc_req_if;
  // registered, cleared in FLUSH
  logic exc_pending;
  logic illegal_pending;
  logic load_err_pending;
  logic store_err_pending;
  // combinational, decoder flags masked with instr valid
  logic special_req;
  logic fetch_err;
  logic ecall;
  logic ebrk;
  logic mret;
  logic wfi;
  // FSM sits in FLUSH
  logic in_flush;

  modport producer (
    output exc_pending, illegal_pending, load_err_pending, store_err_pending,
    output special_req, fetch_err, ecall, ebrk, mret, wfi,
    input  in_flush
  );

  modport consumer (
    input  exc_pending, illegal_pending, load_err_pending, store_err_pending,
    input  special_req, fetch_err, ecall, ebrk, mret, wfi,
    output in_flush
  );
endinterface

// interrupt decision and cause
interface irq_req_if;
  logic                     take_irq;
  logic [`CTRL_CAUSE_W-1:0] irq_cause;
  logic                     irq_is_nmi;
  // NMI handler running, blocks a second NMI
  logic                     nmi_mode;

  modport producer (output take_irq, irq_cause, irq_is_nmi, input nmi_mode);
  modport consumer (input take_irq, irq_cause, irq_is_nmi, output nmi_mode);
endinterface

// ==== source/ctrl_pkg.sv ====
/*
 * types shared by the controller blocks and the testbench
 * vector widths come from the constants header
 */
`include "ctrl_consts.svh"

package ctrl_pkg;

  // instruction, pc, lsu address and trap value
  typedef logic [`CTRL_XLEN-1:0] word_t;

  // compressed instruction as fetched
  typedef logic [`CTRL_CINSN_W-1:0] cinsn_t;

  // one pending bit per fast interrupt
  typedef logic [`CTRL_NFAST-1:0] fast_irq_t;

  // trap cause, bit 5 flags an interrupt
  typedef logic [`CTRL_CAUSE_W-1:0] cause_t;

  // fetch address select
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // exception vector select
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  // controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

endpackage

// ==== source/ctrl_consts.svh ====
/*
 * widths and trap cause codes of the machine-mode controller
 * cause codes are 6 bits wide, bit 5 set marks an interrupt
 */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

// data, address and full instruction width
`define CTRL_XLEN 32
// compressed instruction width
`define CTRL_CINSN_W 16
// number of fast interrupt lines
`define CTRL_NFAST 15
// width of the cause field handed to the CSRs
`define CTRL_CAUSE_W 6

// synchronous exceptions
`define CTRL_EXC_FETCH_FAULT 6'd1
`define CTRL_EXC_ILLEGAL 6'd2
`define CTRL_EXC_BREAKPOINT 6'd3
`define CTRL_EXC_LOAD_FAULT 6'd5
`define CTRL_EXC_STORE_FAULT 6'd7
`define CTRL_EXC_ECALL_M 6'd11

// interrupts, fast line n reports base + n
`define CTRL_IRQ_SW 6'h23
`define CTRL_IRQ_TIMER 6'h27
`define CTRL_IRQ_EXT 6'h2B
`define CTRL_IRQ_NM 6'h3F
`define CTRL_IRQ_FAST_BASE 6'h30

`endif
